// File: hw/vid_cfg.svh
//##########################################################################
// Video subsystem configuration
// Raster geometry, memory address widths and pixel pipeline depth
//##########################################################################

`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// Horizontal raster, in pixels
`define VID_H_TOTAL  64
`define VID_H_ACTIVE 48
`define VID_HS_START 52
`define VID_HS_LEN   4

// Vertical raster, in lines
`define VID_V_TOTAL  40
`define VID_V_ACTIVE 32
`define VID_VS_START 34
`define VID_VS_LEN   2

`define VID_CNT_W    9
`define VID_PAL_AW   6
`define VID_ROM_AW   12

// Pixel enables from raster to RGB
`define VID_PIPE     3

`endif

// File: hw/vid_pkg.sv
//##########################################################################
// Video subsystem types
// Raster bundle, pixel word, mixer controls and CPU bus
//##########################################################################

`default_nettype none

`include "vid_cfg.svh"

package vid_pkg;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] hdump;
        logic [`VID_CNT_W-1:0] vdump;
        logic                  lhbl;
        logic                  lvbl;
        logic                  hs;
        logic                  vs;
    } raster_t;

    // Also used as palette index, layer:bank:colour
    typedef struct packed {
        logic       layer;
        logic       bank;
        logic [3:0] colour;
    } pixel_t;

    typedef struct packed {
        logic [7:0] scroll_x;
        logic       tile_bank;
        logic       tile_over;
        logic       dim_en;
        logic [1:0] dim_amt;
    } mix_cfg_t;

    typedef struct packed {
        logic [6:0]  addr;
        logic [15:0] wdata;
        logic        we;
    } cpu_bus_t;

endpackage

`default_nettype wire

// File: hw/vid_timing.sv
//##########################################################################
// Raster timing generator
// Pixel and line counters with blanking, sync and a frame counter
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_timing import vid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output raster_t    raster,
    output logic [7:0] frame_cnt
);

    localparam logic [`VID_CNT_W-1:0] H_LAST   = `VID_H_TOTAL - 1;
    localparam logic [`VID_CNT_W-1:0] H_ACT    = `VID_H_ACTIVE;
    localparam logic [`VID_CNT_W-1:0] HS_START = `VID_HS_START;
    localparam logic [`VID_CNT_W-1:0] HS_END   = `VID_HS_START + `VID_HS_LEN;
    localparam logic [`VID_CNT_W-1:0] V_LAST   = `VID_V_TOTAL - 1;
    localparam logic [`VID_CNT_W-1:0] V_ACT    = `VID_V_ACTIVE;
    localparam logic [`VID_CNT_W-1:0] VS_START = `VID_VS_START;
    localparam logic [`VID_CNT_W-1:0] VS_END   = `VID_VS_START + `VID_VS_LEN;
    localparam logic [`VID_CNT_W-1:0] VS_PREV  = `VID_VS_START - 1;

    logic [`VID_CNT_W-1:0] hdump;
    logic [`VID_CNT_W-1:0] vdump;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump     <= '0;
            vdump     <= '0;
            frame_cnt <= '0;
        end else if (pxl_cen) begin
            if (hdump == H_LAST) begin
                hdump <= '0;
                vdump <= (vdump == V_LAST) ? '0 : vdump + 1'b1;
                // Frame counts on the line where vs starts
                if (vdump == VS_PREV) begin
                    frame_cnt <= frame_cnt + 8'd1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Blanking and sync decode straight from the counters
    always_comb begin
        raster.hdump = hdump;
        raster.vdump = vdump;
        raster.lhbl  = hdump < H_ACT;
        raster.lvbl  = vdump < V_ACT;
        raster.hs    = (hdump >= HS_START) && (hdump < HS_END);
        raster.vs    = (vdump >= VS_START) && (vdump < VS_END);
    end

endmodule

`default_nettype wire

// File: hw/vid_tile_layer.sv
//##########################################################################
// Scrolling tile layer
// Forms tile ROM row addresses from the scrolled raster position, latches
// the returned row and extracts one 4-bit pixel per pixel enable
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_tile_layer import vid_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  raster_t                raster,
    input  mix_cfg_t               cfg,
    input  logic [31:0]            rom_data,
    output logic [`VID_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    output pixel_t                 tile_pxl
);

    logic [`VID_CNT_W-1:0] col;
    logic [2:0]            sel_q;
    logic [2:0]            idx_q;
    logic [31:0]           row_q;
    logic                  bank_q;

    // Scrolled column, 8 pixels per ROM word
    assign col = raster.hdump + {1'b0, cfg.scroll_x};

    // Address is line row in the upper bits, tile column below it
    assign rom_addr = {{(`VID_ROM_AW - 11){1'b0}}, raster.vdump[4:0], col[8:3]};
    assign rom_cs   = raster.lvbl;

    // Nibble index follows the address by one clock, like the ROM data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else begin
            sel_q <= col[2:0];
        end
    end

    // Row latch on the next pixel enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_q  <= '0;
            idx_q  <= '0;
            bank_q <= 1'b0;
        end else if (pxl_cen) begin
            row_q  <= rom_data;
            idx_q  <= sel_q;
            bank_q <= cfg.tile_bank;
        end
    end

    // Pixel 0 sits in bits 3:0
    always_comb begin
        tile_pxl.layer  = 1'b0;
        tile_pxl.bank   = bank_q;
        tile_pxl.colour = row_q[{idx_q, 2'b00} +: 4];
    end

endmodule

`default_nettype wire

// File: hw/vid_mix_regs.sv
//##########################################################################
// Mixer register block
// CPU-written scroll, bank, priority and dimming controls with read-back
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module vid_mix_regs import vid_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    bus,
    input  logic        regs_cs,
    input  logic [7:0]  frame_cnt,
    output mix_cfg_t    cfg,
    output logic [15:0] reg_rdata
);

    logic        wr_en;
    logic        rd_en;
    logic [15:0] rd_mux;

    assign wr_en = regs_cs && bus.we;
    assign rd_en = regs_cs && !bus.we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (bus.addr)
                7'd0: cfg.scroll_x <= bus.wdata[7:0];
                7'd1: begin
                    cfg.tile_bank <= bus.wdata[0];
                    cfg.tile_over <= bus.wdata[1];
                end
                7'd2: begin
                    cfg.dim_en  <= bus.wdata[0];
                    cfg.dim_amt <= bus.wdata[2:1];
                end
                default: ;
            endcase
        end
    end

    // Undefined bits and addresses read as zero
    always_comb begin
        case (bus.addr)
            7'd0:    rd_mux = {8'd0, cfg.scroll_x};
            7'd1:    rd_mux = {14'd0, cfg.tile_over, cfg.tile_bank};
            7'd2:    rd_mux = {13'd0, cfg.dim_amt, cfg.dim_en};
            7'd3:    rd_mux = {8'd0, frame_cnt};
            default: rd_mux = 16'd0;
        endcase
    end

    // Held until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: hw/vid_palette.sv
//##########################################################################
// Palette RAM
// 64 x 15-bit colours, CPU write and read-back port plus a pixel lookup
// port read every clock
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_palette import vid_pkg::*; (
    input  logic        clk,
    input  cpu_bus_t    bus,
    input  logic        pal_cs,
    input  pixel_t      lookup_idx,
    output logic [15:0] pal_rdata,
    output logic [15:0] lookup_color
);

    localparam int DEPTH = 1 << `VID_PAL_AW;

    // Blue 14:10, green 9:5, red 4:0
    logic [14:0] mem [DEPTH];

    logic [`VID_PAL_AW-1:0] cpu_addr;
    logic [`VID_PAL_AW-1:0] pxl_addr;

    assign cpu_addr = bus.addr[`VID_PAL_AW-1:0];
    assign pxl_addr = lookup_idx;

    // CPU port, the only writer
    always_ff @(posedge clk) begin
        if (pal_cs && bus.we) begin
            mem[cpu_addr] <= bus.wdata[14:0];
        end
    end

    // Read-back holds until the next read
    always_ff @(posedge clk) begin
        if (pal_cs && !bus.we) begin
            pal_rdata <= {1'b0, mem[cpu_addr]};
        end
    end

    // Lookup port, free running
    always_ff @(posedge clk) begin
        lookup_color <= {1'b0, mem[pxl_addr]};
    end

endmodule

`default_nettype wire

// File: hw/vid_colmix.sv
//##########################################################################
// Colour mixer
// Tile/sprite priority, palette lookup, shadow dimming, blanking and
// expansion to 8-bit RGB, with the raster delayed to match
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_colmix import vid_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  raster_t     raster,
    input  pixel_t      tile_pxl,
    input  pixel_t      obj_pxl,
    input  logic        obj_shadow,
    input  mix_cfg_t    cfg,
    output pixel_t      lookup_idx,
    input  logic [15:0] lookup_color,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output raster_t     raster_out
);

    raster_t    rpipe [`VID_PIPE];
    pixel_t     obj_q;
    logic       shd_q;
    logic       dim_q;
    logic [1:0] amt_q;
    logic       obj_wins;
    logic       blank;

    // Shift right by the dim amount, then repeat the top 3 bits below
    function automatic logic [7:0] chan(input logic [4:0] c, input logic dim,
                                        input logic [1:0] amt);
        logic [4:0] d;
        d    = dim ? (c >> amt) : c;
        chan = {d, d[4:2]};
    endfunction

    assign obj_wins = (obj_q.colour != 4'd0) &&
                      !(cfg.tile_over && (tile_pxl.colour != 4'd0));
    assign blank    = !rpipe[`VID_PIPE-2].lhbl || !rpipe[`VID_PIPE-2].lvbl;
    assign raster_out = rpipe[`VID_PIPE-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rpipe      <= '{default: '0};
            obj_q      <= '0;
            shd_q      <= 1'b0;
            lookup_idx <= '0;
            dim_q      <= 1'b0;
            amt_q      <= '0;
            red        <= '0;
            green      <= '0;
            blue       <= '0;
        end else if (pxl_cen) begin
            rpipe[0] <= raster;
            for (int i = 1; i < `VID_PIPE; i++) begin
                rpipe[i] <= rpipe[i-1];
            end
            // Sprite sampled in step with the tile row latch
            obj_q <= obj_pxl;
            shd_q <= obj_shadow;
            // Selection drives the palette lookup port
            lookup_idx <= obj_wins ? obj_q : tile_pxl;
            dim_q      <= shd_q && cfg.dim_en;
            amt_q      <= cfg.dim_amt;
            // Palette data arrived one clock after the selection
            red   <= blank ? 8'd0 : chan(lookup_color[4:0], dim_q, amt_q);
            green <= blank ? 8'd0 : chan(lookup_color[9:5], dim_q, amt_q);
            blue  <= blank ? 8'd0 : chan(lookup_color[14:10], dim_q, amt_q);
        end
    end

endmodule

`default_nettype wire

// File: hw/vid_top.sv
//##########################################################################
// Video subsystem top level
// Timing, tile layer, mixer registers, palette and colour mixer
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_top import vid_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  cpu_bus_t               bus,
    input  logic                   regs_cs,
    input  logic                   pal_cs,
    input  logic [31:0]            rom_data,
    input  pixel_t                 obj_pxl,
    input  logic                   obj_shadow,
    output logic [15:0]            cpu_rdata,
    output logic [`VID_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    output logic [7:0]             red,
    output logic [7:0]             green,
    output logic [7:0]             blue,
    output logic                   lhbl,
    output logic                   lvbl,
    output logic                   hs,
    output logic                   vs
);

    raster_t     raster;
    raster_t     raster_out;
    mix_cfg_t    cfg;
    pixel_t      tile_pxl;
    pixel_t      lookup_idx;
    logic [15:0] lookup_color;
    logic [15:0] reg_rdata;
    logic [15:0] pal_rdata;
    logic [7:0]  frame_cnt;
    logic        rd_pal_q;

    // Source of the last read, both read registers hold their data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pal_q <= 1'b0;
        end else if ((regs_cs || pal_cs) && !bus.we) begin
            rd_pal_q <= pal_cs;
        end
    end

    assign cpu_rdata = rd_pal_q ? pal_rdata : reg_rdata;

    assign lhbl = raster_out.lhbl;
    assign lvbl = raster_out.lvbl;
    assign hs   = raster_out.hs;
    assign vs   = raster_out.vs;

    vid_timing i_timing (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen),
        .raster(raster), .frame_cnt(frame_cnt)
    );

    vid_tile_layer i_tile (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .raster(raster), .cfg(cfg),
        .rom_data(rom_data), .rom_addr(rom_addr), .rom_cs(rom_cs), .tile_pxl(tile_pxl)
    );

    vid_mix_regs i_regs (
        .clk(clk), .rst_n(rst_n), .bus(bus), .regs_cs(regs_cs),
        .frame_cnt(frame_cnt), .cfg(cfg), .reg_rdata(reg_rdata)
    );

    vid_palette i_pal (
        .clk(clk), .bus(bus), .pal_cs(pal_cs), .lookup_idx(lookup_idx),
        .pal_rdata(pal_rdata), .lookup_color(lookup_color)
    );

    vid_colmix i_colmix (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .raster(raster),
        .tile_pxl(tile_pxl), .obj_pxl(obj_pxl), .obj_shadow(obj_shadow), .cfg(cfg),
        .lookup_idx(lookup_idx), .lookup_color(lookup_color),
        .red(red), .green(green), .blue(blue), .raster_out(raster_out)
    );

endmodule

`default_nettype wire

// File: tb/vid_tb.sv
//##########################################################################
// Video subsystem testbench
// Tile ROM model, CPU bus tasks and a pixel reference model that checks
// raster timing, read-back, scrolling, priority, dimming and blanking
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

`include "vid_cfg.svh"

module vid_tb import vid_pkg::*; ();

    localparam int CLK_NS      = 40;
    localparam int PHASE_EN    = 1280;
    localparam int FRAME_NS    = `VID_H_TOTAL * `VID_V_TOTAL * 2 * CLK_NS;
    localparam int WATCHDOG_NS = 6 * FRAME_NS + 2000 * CLK_NS;

    typedef logic [`VID_ROM_AW-1:0] rom_addr_t;

    // One expected output pixel with its raster flags
    typedef struct packed {
        logic       chk;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pxl_cen = 1'b0;
    cpu_bus_t    bus;
    logic        regs_cs;
    logic        pal_cs;
    logic [31:0] rom_data = '0;
    pixel_t      obj_pxl = '0;
    logic        obj_shadow = 1'b0;
    logic [15:0] cpu_rdata;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;

    // Reference model state
    logic        en_seen = 1'b0;
    logic        pix_chk = 1'b0;
    logic        obj_mode = 1'b0;
    int          h = 0;
    int          v = 0;
    exp_t        exp_q[$];
    logic [14:0] pal_m [64];
    logic [7:0]  scroll_m = '0;
    logic        bank_m = 1'b0;
    logic        over_m = 1'b0;
    logic        dim_en_m = 1'b0;
    logic [1:0]  amt_m = '0;
    logic [7:0]  frames_m = '0;

    vid_top i_vid_top (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .bus(bus),
        .regs_cs(regs_cs), .pal_cs(pal_cs), .rom_data(rom_data),
        .obj_pxl(obj_pxl), .obj_shadow(obj_shadow), .cpu_rdata(cpu_rdata),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .red(red), .green(green),
        .blue(blue), .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] rom_word(input rom_addr_t adr);
        return {adr[7:0], adr, adr} ^ 32'h5A3C_96E1;
    endfunction

    // 5-bit channel to 8 bits with the top bits repeated below
    function automatic logic [7:0] expand(input logic [4:0] c, input logic dim,
                                          input logic [1:0] amt);
        logic [4:0] d;
        d = c;
        if (dim) begin
            d = c >> amt;
        end
        return {d, 3'b000} | 8'(d >> 2);
    endfunction

    function automatic logic [15:0] reg_mask(input int r);
        if (r == 0) begin
            return 16'h00FF;
        end else if (r == 1) begin
            return 16'h0003;
        end
        return 16'h0007;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] want);
        assert (got === want)
            else report_fail($sformatf("FAIL %s: got %h expected %h", name, got, want));
    endtask

    // ROM answers one clock after the address
    always @(posedge clk) begin
        if (rom_cs) begin
            rom_data <= rom_word(rom_addr);
        end
    end

    // Pixel enable every second clock with the sprite input changing in between
    always @(posedge clk) begin
        pxl_cen <= !pxl_cen;
        en_seen <= pxl_cen && rst_n;
        if (!pxl_cen) begin
            obj_pxl.layer  <= 1'b1;
            obj_pxl.bank   <= 1'($urandom);
            obj_pxl.colour <= obj_mode ? 4'($urandom) : 4'd0;
            obj_shadow     <= 1'($urandom);
        end
    end

    task automatic cpu_write(input logic to_pal, input logic [6:0] adr,
                             input logic [15:0] data);
        @(posedge clk);
        bus     <= '{addr: adr, wdata: data, we: 1'b1};
        regs_cs <= !to_pal;
        pal_cs  <= to_pal;
        @(posedge clk);
        bus.we  <= 1'b0;
        regs_cs <= 1'b0;
        pal_cs  <= 1'b0;
        if (to_pal) begin
            pal_m[adr[5:0]] = data[14:0];
        end else if (adr == 7'd0) begin
            scroll_m = data[7:0];
        end else if (adr == 7'd1) begin
            bank_m = data[0];
            over_m = data[1];
        end else if (adr == 7'd2) begin
            dim_en_m = data[0];
            amt_m    = data[2:1];
        end
    endtask

    task automatic cpu_read(input logic to_pal, input logic [6:0] adr,
                            input logic [15:0] want);
        @(posedge clk);
        bus     <= '{addr: adr, wdata: 16'h0000, we: 1'b0};
        regs_cs <= !to_pal;
        pal_cs  <= to_pal;
        @(posedge clk);
        regs_cs <= 1'b0;
        pal_cs  <= 1'b0;
        @(negedge clk);
        check_val("cpu_rdata", cpu_rdata, want);
    endtask

    // Frame counter read against the model count at the sampling edge
    task automatic read_frame_cnt();
        logic [15:0] want;
        @(posedge clk);
        bus     <= '{addr: 7'd3, wdata: 16'h0000, we: 1'b0};
        regs_cs <= 1'b1;
        pal_cs  <= 1'b0;
        @(posedge clk);
        want    = {8'h00, frames_m};
        regs_cs <= 1'b0;
        @(negedge clk);
        check_val("cpu_rdata", cpu_rdata, want);
    endtask

    task automatic wait_enables(input int n);
        repeat (2 * n) @(posedge clk);
    endtask

    task automatic set_cfg(input logic [7:0] scroll, input logic bank, input logic over,
                           input logic den, input logic [1:0] amt);
        cpu_write(1'b0, 7'd0, {8'h00, scroll});
        cpu_write(1'b0, 7'd1, {14'd0, over, bank});
        cpu_write(1'b0, 7'd2, {13'd0, amt, den});
    endtask

    // Pixel checks run with a stable configuration only
    task automatic run_phase();
        wait_enables(2);
        pix_chk = 1'b1;
        wait_enables(PHASE_EN);
        pix_chk = 1'b0;
        wait_enables(`VID_PIPE);
    endtask

    task automatic model_step();
        exp_t        e;
        logic [8:0]  colv;
        rom_addr_t   adr;
        logic [3:0]  tcol;
        logic [5:0]  idx;
        logic [14:0] c;
        logic        dim;
        logic        blank;
        e.chk  = pix_chk;
        e.lhbl = (h < `VID_H_ACTIVE);
        e.lvbl = (v < `VID_V_ACTIVE);
        e.hs   = (h >= `VID_HS_START) && (h < `VID_HS_START + `VID_HS_LEN);
        e.vs   = (v >= `VID_VS_START) && (v < `VID_VS_START + `VID_VS_LEN);
        // Row of the line with eight pixels per ROM word
        colv = 9'(h + int'(scroll_m));
        adr  = rom_addr_t'((v % 32) * 64 + colv / 8);
        tcol = 4'(rom_word(adr) >> (4 * colv[2:0]));
        // Sprite wins unless a priority tile is opaque
        if (obj_pxl.colour != 4'd0 && !(over_m && tcol != 4'd0)) begin
            idx = obj_pxl;
        end else begin
            idx = {1'b0, bank_m, tcol};
        end
        c     = pal_m[idx];
        dim   = obj_shadow && dim_en_m;
        blank = !e.lhbl || !e.lvbl;
        e.r   = blank ? 8'd0 : expand(c[4:0], dim, amt_m);
        e.g   = blank ? 8'd0 : expand(c[9:5], dim, amt_m);
        e.b   = blank ? 8'd0 : expand(c[14:10], dim, amt_m);
        exp_q.push_back(e);
        h = h + 1;
        if (h == `VID_H_TOTAL) begin
            h = 0;
            v = (v == `VID_V_TOTAL - 1) ? 0 : v + 1;
            if (v == `VID_VS_START) begin
                frames_m = frames_m + 8'd1;
            end
        end
        // Tile ROM is selected on active lines of the current raster
        check_val("rom_cs", 16'(rom_cs), 16'(v < `VID_V_ACTIVE));
        if (exp_q.size() == `VID_PIPE) begin
            e = exp_q.pop_front();
            check_val("lhbl", 16'(lhbl), 16'(e.lhbl));
            check_val("lvbl", 16'(lvbl), 16'(e.lvbl));
            check_val("hs", 16'(hs), 16'(e.hs));
            check_val("vs", 16'(vs), 16'(e.vs));
            if (e.chk) begin
                check_val("red", 16'(red), 16'(e.r));
                check_val("green", 16'(green), 16'(e.g));
                check_val("blue", 16'(blue), 16'(e.b));
            end
        end
        if (!lhbl || !lvbl) begin
            assert ({red, green, blue} == 24'h000000)
                else report_fail($sformatf("FAIL rgb: got %h expected 000000",
                                           {red, green, blue}));
        end
    endtask

    always @(negedge clk) begin
        if (en_seen) begin
            model_step();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_fail("Watchdog timeout, the test sequence did not finish in time");
    end

    initial begin
        logic [15:0] d;
        void'($urandom(45));
        rst_n   = 1'b0;
        bus     = '0;
        regs_cs = 1'b0;
        pal_cs  = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Register and palette read-back
        repeat (4) begin
            for (int r = 0; r < 3; r++) begin
                d = 16'($urandom);
                cpu_write(1'b0, 7'(r), d);
                cpu_read(1'b0, 7'(r), d & reg_mask(r));
            end
        end
        for (int i = 0; i < 64; i++) begin
            cpu_write(1'b1, 7'(i), 16'($urandom));
        end
        for (int i = 0; i < 64; i++) begin
            cpu_read(1'b1, 7'(i), {1'b0, pal_m[i]});
        end
        cpu_read(1'b0, 7'd0, {8'h00, scroll_m});

        // Tile layer alone at two scroll positions
        obj_mode <= 1'b0;
        set_cfg(8'($urandom), 1'b1, 1'b0, 1'b0, 2'd0);
        run_phase();
        set_cfg(8'($urandom), 1'b0, 1'b0, 1'b0, 2'd0);
        run_phase();

        // Sprite priority, then shadow at each dim amount
        obj_mode <= 1'b1;
        for (int o = 0; o < 2; o++) begin
            set_cfg(8'($urandom), 1'($urandom), 1'(o), 1'b0, 2'd0);
            run_phase();
        end
        for (int a = 0; a < 4; a++) begin
            set_cfg(8'($urandom), 1'($urandom), 1'b0, 1'b1, 2'(a));
            run_phase();
        end

        read_frame_cnt();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/vid_pkg.sv
hw/vid_timing.sv
hw/vid_tile_layer.sv
hw/vid_mix_regs.sv
hw/vid_palette.sv
hw/vid_colmix.sv
hw/vid_top.sv
tb/vid_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module vid_tb -Mdir obj_dir -f list.f
./obj_dir/Vvid_tb | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
